// File: hdl/flit_buffer_pkg.sv
`default_nettype none

package flit_buffer_pkg;

    localparam int num_vc         = 4;
    localparam int vc_depth       = 4;  // slots per vc, power of two
    localparam int payload_width  = 32;
    localparam int class_width    = 2;
    localparam int ptr_width      = 2;  // log2(vc_depth)
    localparam int vc_index_width = 2;  // log2(num_vc)
    localparam int ram_addr_width = ptr_width + vc_index_width;

    typedef logic [num_vc-1:0]         vc_mask_t;   // one-hot select or per-vc flags
    typedef logic [ptr_width-1:0]      vc_ptr_t;
    typedef logic [ptr_width:0]        vc_depth_t;  // 0 .. vc_depth
    typedef logic [ram_addr_width-1:0] ram_addr_t;  // {vc index, slot}
    typedef logic [class_width-1:0]    flit_class_t;

    // full flit as seen on the link
    typedef struct packed {
        flit_class_t              flit_class;  // head/tail marking
        vc_mask_t                 vc;
        logic [payload_width-1:0] payload;
    } flit_t;

    // what actually sits in the shared memory, vc is implied by the address
    typedef struct packed {
        flit_class_t              flit_class;
        logic [payload_width-1:0] payload;
    } ram_word_t;

    // one-hot to binary, a zero mask gives index 0
    function automatic logic [vc_index_width-1:0] vc_index(input vc_mask_t mask);
        logic [vc_index_width-1:0] idx;
        idx = '0;
        for (int i = 0; i < num_vc; i++) begin
            if (mask[i]) begin
                idx |= vc_index_width'(i);
            end
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

// File: hdl/vc_pointer_bank.sv
`timescale 1ns/1ps
`default_nettype none

module vc_pointer_bank
    import flit_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      wr_en,
    input  logic      rd_en,
    input  vc_mask_t  wr_vc,
    input  vc_mask_t  rd_vc,
    output ram_addr_t wr_addr,
    output ram_addr_t rd_addr,
    output vc_mask_t  vc_not_empty
);

    vc_mask_t  wr_pulse;  // per-vc write this cycle
    vc_mask_t  rd_pulse;  // per-vc read this cycle

    vc_ptr_t   wr_ptr [num_vc];
    vc_ptr_t   rd_ptr [num_vc];
    vc_depth_t depth  [num_vc];

    vc_ptr_t   wr_slot;  // slot of the selected write vc
    vc_ptr_t   rd_slot;  // slot of the selected read vc

    assign wr_pulse = wr_en ? wr_vc : '0;
    assign rd_pulse = rd_en ? rd_vc : '0;

    // pointer and occupancy state, one set per vc
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_vc; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                depth[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < num_vc; i++) begin
                if (wr_pulse[i]) begin
                    wr_ptr[i] <= wr_ptr[i] + 1'b1;  // wraps inside the vc region
                end
                if (rd_pulse[i]) begin
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
                end

                // simultaneous read and write leaves depth alone
                if (wr_pulse[i] && !rd_pulse[i]) begin
                    depth[i] <= depth[i] + 1'b1;
                end else if (!wr_pulse[i] && rd_pulse[i]) begin
                    depth[i] <= depth[i] - 1'b1;
                end
            end
        end
    end

    // one-hot pointer mux, selects are one-hot so OR-ing is enough
    always_comb begin
        wr_slot = '0;
        rd_slot = '0;
        for (int i = 0; i < num_vc; i++) begin
            if (wr_vc[i]) begin
                wr_slot |= wr_ptr[i];
            end
            if (rd_vc[i]) begin
                rd_slot |= rd_ptr[i];
            end
        end
    end

    // region base from the vc index, offset from the slot pointer
    assign wr_addr = {vc_index(wr_vc), wr_slot};
    assign rd_addr = {vc_index(rd_vc), rd_slot};

    always_comb begin
        for (int i = 0; i < num_vc; i++) begin
            vc_not_empty[i] = (depth[i] != '0);
        end
    end

endmodule

`default_nettype wire

// File: hdl/flit_queue_ram.sv
`timescale 1ns/1ps
`default_nettype none

module flit_queue_ram
    import flit_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      wr_en,
    input  logic      rd_en,
    input  ram_addr_t wr_addr,
    input  ram_addr_t rd_addr,
    input  ram_word_t wr_data,
    output ram_word_t rd_data
);

    // all vcs share this array, num_vc regions of vc_depth words
    ram_word_t mem [num_vc*vc_depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read port, holds the last word between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/flit_read_stage.sv
`timescale 1ns/1ps
`default_nettype none

module flit_read_stage
    import flit_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      rd_en,
    input  vc_mask_t  rd_vc,
    input  ram_word_t rd_data,
    output flit_t     flit_out,
    output logic      flit_out_valid
);

    vc_mask_t rd_vc_q;  // vc of the word now on rd_data
    logic     loaded;   // rd_data holds a real word

    // aligned with the memory output register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_vc_q        <= '0;
            loaded         <= 1'b0;
            flit_out_valid <= 1'b0;
        end else begin
            flit_out_valid <= rd_en;  // one cycle per read strobe
            if (rd_en) begin
                rd_vc_q <= rd_vc;
                loaded  <= 1'b1;
            end
        end
    end

    // rebuild the flit, vc field names the queue it came from
    always_comb begin
        flit_out = '0;
        if (loaded) begin
            flit_out.flit_class = rd_data.flit_class;
            flit_out.vc         = rd_vc_q;
            flit_out.payload    = rd_data.payload;
        end
    end

endmodule

`default_nettype wire

// File: hdl/flit_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module flit_buffer
    import flit_buffer_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     wr_en,
    input  vc_mask_t wr_vc,
    input  flit_t    flit_in,
    input  logic     rd_en,
    input  vc_mask_t rd_vc,
    output flit_t    flit_out,
    output logic     flit_out_valid,
    output vc_mask_t vc_not_empty
);

    ram_addr_t wr_addr;
    ram_addr_t rd_addr;
    ram_word_t wr_data;
    ram_word_t rd_data;

    // vc field is dropped, the address already carries it
    assign wr_data.flit_class = flit_in.flit_class;
    assign wr_data.payload    = flit_in.payload;

    vc_pointer_bank vc_pointer_bank_i (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .wr_vc        (wr_vc),
        .rd_vc        (rd_vc),
        .wr_addr      (wr_addr),
        .rd_addr      (rd_addr),
        .vc_not_empty (vc_not_empty)
    );

    flit_queue_ram flit_queue_ram_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .wr_data (wr_data),
        .rd_data (rd_data)
    );

    // one cycle read latency, matches the ram output register
    flit_read_stage flit_read_stage_i (
        .clk            (clk),
        .reset          (reset),
        .rd_en          (rd_en),
        .rd_vc          (rd_vc),
        .rd_data        (rd_data),
        .flit_out       (flit_out),
        .flit_out_valid (flit_out_valid)
    );

endmodule

`default_nettype wire

// File: dv/flit_buffer_vectors.svh
`ifndef FLIT_BUFFER_VECTORS_SVH
`define FLIT_BUFFER_VECTORS_SVH

function automatic flit_t make_flit(input flit_class_t cls, input vc_mask_t vc,
                                    input logic [payload_width-1:0] payload);
    flit_t f;
    f.flit_class = cls;
    f.vc         = vc;
    f.payload    = payload;
    return f;
endfunction

// row holds name, write strobe/vc/flit, read strobe/vc, expected flit and vc_not_empty
task automatic push_row(input string name, input logic wr, input vc_mask_t wvc,
                        input flit_t fin, input logic rd, input vc_mask_t rvc,
                        input flit_t exp, input vc_mask_t ne);
    stim_row_t r;
    r.wr_en         = wr;
    r.wr_vc         = wvc;
    r.flit_in       = fin;
    r.rd_en         = rd;
    r.rd_vc         = rvc;
    r.exp_flit      = exp;
    r.flit_check    = rd;  // flit_out only compared after a read
    r.exp_not_empty = ne;
    rows.push_back(r);
    row_names.push_back(name);
endtask

task automatic idle_row(input string name, input vc_mask_t ne);
    push_row(name, 1'b0, '0, '0, 1'b0, '0, '0, ne);
endtask

task automatic write_row(input string name, input vc_mask_t wvc, input flit_class_t cls,
                         input logic [payload_width-1:0] payload, input vc_mask_t ne);
    push_row(name, 1'b1, wvc, make_flit(cls, wvc, payload), 1'b0, '0, '0, ne);
endtask

// outgoing vc field must name the vc that was read
task automatic read_row(input string name, input vc_mask_t rvc, input flit_class_t cls,
                        input logic [payload_width-1:0] payload, input vc_mask_t ne);
    push_row(name, 1'b0, '0, '0, 1'b1, rvc, make_flit(cls, rvc, payload), ne);
endtask

task automatic both_row(input string name, input vc_mask_t wvc, input flit_class_t wcls,
                        input logic [payload_width-1:0] wpay, input vc_mask_t rvc,
                        input flit_class_t rcls, input logic [payload_width-1:0] rpay,
                        input vc_mask_t ne);
    push_row(name, 1'b1, wvc, make_flit(wcls, wvc, wpay), 1'b1, rvc,
             make_flit(rcls, rvc, rpay), ne);
endtask

task automatic build_table();
    logic [payload_width-1:0] pay [8];
    for (int i = 0; i < 8; i++) begin
        pay[i] = $urandom;  // filler payloads for the interleaved part
    end

    idle_row("reset_idle_0", 4'b0000);
    idle_row("reset_idle_1", 4'b0000);

    // three flits through vc1
    write_row("one_vc_wr0", 4'b0010, 2'b10, 32'hA100_0001, 4'b0010);
    write_row("one_vc_wr1", 4'b0010, 2'b00, 32'hA100_0002, 4'b0010);
    // stray vc field on flit_in that must not be stored
    push_row("one_vc_wr2", 1'b1, 4'b0010, make_flit(2'b01, 4'b0100, 32'hA100_0003),
             1'b0, '0, '0, 4'b0010);
    read_row("one_vc_rd0", 4'b0010, 2'b10, 32'hA100_0001, 4'b0010);
    read_row("one_vc_rd1", 4'b0010, 2'b00, 32'hA100_0002, 4'b0010);
    read_row("one_vc_rd2", 4'b0010, 2'b01, 32'hA100_0003, 4'b0000);
    idle_row("one_vc_gap", 4'b0000);

    // two flits per vc written interleaved
    write_row("mix_wr_vc0_a", 4'b0001, 2'b10, pay[0], 4'b0001);
    write_row("mix_wr_vc2_a", 4'b0100, 2'b10, pay[1], 4'b0101);
    write_row("mix_wr_vc3_a", 4'b1000, 2'b10, pay[2], 4'b1101);
    write_row("mix_wr_vc1_a", 4'b0010, 2'b10, pay[3], 4'b1111);
    write_row("mix_wr_vc0_b", 4'b0001, 2'b01, pay[4], 4'b1111);
    write_row("mix_wr_vc2_b", 4'b0100, 2'b01, pay[5], 4'b1111);
    write_row("mix_wr_vc3_b", 4'b1000, 2'b01, pay[6], 4'b1111);
    write_row("mix_wr_vc1_b", 4'b0010, 2'b01, pay[7], 4'b1111);

    // read order across vcs differs from write order
    read_row("mix_rd_vc3_a", 4'b1000, 2'b10, pay[2], 4'b1111);
    read_row("mix_rd_vc1_a", 4'b0010, 2'b10, pay[3], 4'b1111);
    read_row("mix_rd_vc0_a", 4'b0001, 2'b10, pay[0], 4'b1111);
    read_row("mix_rd_vc3_b", 4'b1000, 2'b01, pay[6], 4'b0111);
    read_row("mix_rd_vc2_a", 4'b0100, 2'b10, pay[1], 4'b0111);
    read_row("mix_rd_vc0_b", 4'b0001, 2'b01, pay[4], 4'b0110);
    read_row("mix_rd_vc1_b", 4'b0010, 2'b01, pay[7], 4'b0100);
    read_row("mix_rd_vc2_b", 4'b0100, 2'b01, pay[5], 4'b0000);

    // fill vc2 from mid-region so the pointers wrap
    write_row("full_wr0", 4'b0100, 2'b10, 32'hC400_0000, 4'b0100);
    write_row("full_wr1", 4'b0100, 2'b00, 32'hC400_0001, 4'b0100);
    write_row("full_wr2", 4'b0100, 2'b00, 32'hC400_0002, 4'b0100);
    write_row("full_wr3", 4'b0100, 2'b00, 32'hC400_0003, 4'b0100);
    both_row("full_rd_wr", 4'b0100, 2'b01, 32'hC400_0004,
             4'b0100, 2'b10, 32'hC400_0000, 4'b0100);
    read_row("full_rd1", 4'b0100, 2'b00, 32'hC400_0001, 4'b0100);
    read_row("full_rd2", 4'b0100, 2'b00, 32'hC400_0002, 4'b0100);
    read_row("full_rd3", 4'b0100, 2'b00, 32'hC400_0003, 4'b0100);
    read_row("full_rd4", 4'b0100, 2'b01, 32'hC400_0004, 4'b0000);

    // write one vc while reading another
    write_row("cross_wr_vc0", 4'b0001, 2'b11, 32'hD500_0001, 4'b0001);
    both_row("cross_wr3_rd0", 4'b1000, 2'b11, 32'hD500_0002,
             4'b0001, 2'b11, 32'hD500_0001, 4'b1000);
    both_row("cross_wr1_rd3", 4'b0010, 2'b11, 32'hD500_0003,
             4'b1000, 2'b11, 32'hD500_0002, 4'b0010);
    read_row("cross_rd1", 4'b0010, 2'b11, 32'hD500_0003, 4'b0000);
    idle_row("final_idle", 4'b0000);
endtask

`endif

// File: dv/flit_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module flit_buffer_tb
    import flit_buffer_pkg::*;
();

    // one table row applied for one clock cycle
    typedef struct packed {
        logic     wr_en;
        vc_mask_t wr_vc;
        flit_t    flit_in;
        logic     rd_en;
        vc_mask_t rd_vc;
        flit_t    exp_flit;       // flit_out expected in the cycle after the row
        logic     flit_check;
        vc_mask_t exp_not_empty;  // vc_not_empty after the row's edge
    } stim_row_t;

    logic     clk;
    logic     reset;
    logic     wr_en;
    vc_mask_t wr_vc;
    flit_t    flit_in;
    logic     rd_en;
    vc_mask_t rd_vc;
    flit_t    flit_out;
    logic     flit_out_valid;
    vc_mask_t vc_not_empty;

    stim_row_t rows [$];
    string     row_names [$];

    int value_errors;
    int valid_errors;
    int cycle_count;
    int cycle_limit;

    `include "flit_buffer_vectors.svh"

    flit_buffer flit_buffer_i (
        .clk            (clk),
        .reset          (reset),
        .wr_en          (wr_en),
        .wr_vc          (wr_vc),
        .flit_in        (flit_in),
        .rd_en          (rd_en),
        .rd_vc          (rd_vc),
        .flit_out       (flit_out),
        .flit_out_valid (flit_out_valid),
        .vc_not_empty   (vc_not_empty)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // guard against a stuck run
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_flit(input string name, input flit_t expected, input flit_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s flit_out: expected %b/%b/%h actual %b/%b/%h",
                     name, expected.flit_class, expected.vc, expected.payload,
                     actual.flit_class, actual.vc, actual.payload);
        end
    endtask

    task automatic check_vc_mask(input string name, input vc_mask_t expected,
                                 input vc_mask_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s vc_not_empty: expected %b actual %b", name, expected, actual);
        end
    endtask

    // valid must follow each read strobe by exactly one cycle
    task automatic check_valid(input string name, input logic expected);
        if (flit_out_valid !== expected) begin
            valid_errors++;
            if (expected) begin
                $display("row %s: read strobe was not followed by flit_out_valid", name);
            end else begin
                $display("row %s: flit_out_valid came high without a read strobe", name);
            end
        end
    endtask

    task automatic drive_row(input stim_row_t r);
        wr_en   <= r.wr_en;
        wr_vc   <= r.wr_vc;
        flit_in <= r.flit_in;
        rd_en   <= r.rd_en;
        rd_vc   <= r.rd_vc;
    endtask

    task automatic drive_idle();
        wr_en <= 1'b0;
        rd_en <= 1'b0;
    endtask

    initial begin
        int n;
        value_errors = 0;
        valid_errors = 0;
        cycle_count  = 0;
        cycle_limit  = 0;
        reset        = 1'b1;
        wr_en        = 1'b0;
        wr_vc        = '0;
        flit_in      = '0;
        rd_en        = 1'b0;
        rd_vc        = '0;

        void'($urandom(16068));
        build_table();
        n           = rows.size();
        cycle_limit = 2 * n + 20;

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // row i is driven while row i-1 is checked at the falling edge
        for (int i = 0; i <= n; i++) begin
            @(posedge clk);
            if (i < n) begin
                drive_row(rows[i]);
            end else begin
                drive_idle();
            end
            @(negedge clk);
            if (i == 0) begin
                check_vc_mask("after_reset", '0, vc_not_empty);
                check_valid("after_reset", 1'b0);
                check_flit("after_reset", '0, flit_out);  // cleared until the first read
            end else begin
                check_vc_mask(row_names[i-1], rows[i-1].exp_not_empty, vc_not_empty);
                check_valid(row_names[i-1], rows[i-1].rd_en);
                if (rows[i-1].flit_check) begin
                    check_flit(row_names[i-1], rows[i-1].exp_flit, flit_out);
                end
            end
        end

        $display("rows: %0d, value errors: %0d, valid errors: %0d",
                 n, value_errors, valid_errors);
        if (value_errors == 0 && valid_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+dv
hdl/flit_buffer_pkg.sv
hdl/vc_pointer_bank.sv
hdl/flit_queue_ram.sv
hdl/flit_read_stage.sv
hdl/flit_buffer.sv
dv/flit_buffer_tb.sv
